/* cdp_rdma_reg.f */
hdl/csb_pkg.sv
hdl/cdp_rdma_reg_pkg.sv
hdl/reg_bus_if.sv
hdl/csb_reg_bridge.sv
hdl/cdp_rdma_reg_single.sv
hdl/cdp_rdma_reg_dual.sv
hdl/cdp_rdma_pingpong_ctrl.sv
hdl/cdp_rdma_reg.sv
bench/cdp_rdma_reg_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the cdp_rdma_reg testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --top-module cdp_rdma_reg_tb \
    -f cdp_rdma_reg.f -o sim_cdp_rdma_reg; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_cdp_rdma_reg > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS PASSED" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

/* bench/cdp_rdma_reg_tb.sv */
// cdp rdma register file testbench
`timescale 1ns/1ps

module cdp_rdma_reg_tb;

  localparam int num_ops      = 600;
  localparam int reset_cycles = 16;
  localparam int cycle_limit  = 4000;  // 600 ops x up to 3 cycles + reset, ~2x margin

  logic        nvdla_core_clk;
  logic        nvdla_core_rstn;
  logic [62:0] csb2cdp_rdma_req_pd;
  logic        csb2cdp_rdma_req_pvld;
  logic        csb2cdp_rdma_req_prdy;
  logic [33:0] cdp_rdma2csb_resp_pd;
  logic        cdp_rdma2csb_resp_valid;
  logic        dp2reg_done;
  logic [31:0] dp2reg_d0_perf_read_stall;
  logic [31:0] dp2reg_d1_perf_read_stall;
  logic [12:0] reg2dp_width;
  logic [12:0] reg2dp_height;
  logic [12:0] reg2dp_channel;
  logic [26:0] reg2dp_src_base_addr_low;
  logic [31:0] reg2dp_src_base_addr_high;
  logic [26:0] reg2dp_src_line_stride;
  logic [26:0] reg2dp_src_surface_stride;
  logic        reg2dp_src_ram_type;
  logic [1:0]  reg2dp_input_data;
  logic        reg2dp_dma_en;
  logic        reg2dp_op_en;
  logic        slcg_op_en;

  int seed;
  int cycle_count;

  ////////////////////////////////////////
  // reference model state
  ////////////////////////////////////////
  logic        m_vld;               // request held in bridge stage
  logic [62:0] m_pd;
  logic        producer_m;
  logic        consumer_m;
  logic [1:0]  en_m;                // op enable per group
  logic [31:0] regs_m [0:1][0:9];   // 0x00c..0x030, stored masked
  logic [2:0]  op_hist;
  logic [2:0]  slcg_hist;
  logic        resp_vld_m;
  logic [33:0] resp_pd_m;

  cdp_rdma_reg dut0 (
    .nvdla_core_clk            (nvdla_core_clk),
    .nvdla_core_rstn           (nvdla_core_rstn),
    .csb2cdp_rdma_req_pd       (csb2cdp_rdma_req_pd),
    .csb2cdp_rdma_req_pvld     (csb2cdp_rdma_req_pvld),
    .csb2cdp_rdma_req_prdy     (csb2cdp_rdma_req_prdy),
    .cdp_rdma2csb_resp_pd      (cdp_rdma2csb_resp_pd),
    .cdp_rdma2csb_resp_valid   (cdp_rdma2csb_resp_valid),
    .dp2reg_done               (dp2reg_done),
    .dp2reg_d0_perf_read_stall (dp2reg_d0_perf_read_stall),
    .dp2reg_d1_perf_read_stall (dp2reg_d1_perf_read_stall),
    .reg2dp_width              (reg2dp_width),
    .reg2dp_height             (reg2dp_height),
    .reg2dp_channel            (reg2dp_channel),
    .reg2dp_src_base_addr_low  (reg2dp_src_base_addr_low),
    .reg2dp_src_base_addr_high (reg2dp_src_base_addr_high),
    .reg2dp_src_line_stride    (reg2dp_src_line_stride),
    .reg2dp_src_surface_stride (reg2dp_src_surface_stride),
    .reg2dp_src_ram_type       (reg2dp_src_ram_type),
    .reg2dp_input_data         (reg2dp_input_data),
    .reg2dp_dma_en             (reg2dp_dma_en),
    .reg2dp_op_en              (reg2dp_op_en),
    .slcg_op_en                (slcg_op_en)
  );

  always #2 nvdla_core_clk = ~nvdla_core_clk;  // 4 ns period

  // watchdog
  always @(posedge nvdla_core_clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout, simulation ran past %0d clock cycles", cycle_limit);
      fail_run();
    end
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////
  task automatic fail_run();
    $display("TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_val(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
    assert (got === exp) else begin
      $display("[ERROR] %s got 0x%0h expected 0x%0h at cycle %0d", name, got, exp,
               cycle_count);
      fail_run();
    end
  endtask

  function automatic logic [31:0] rand32();
    rand32 = $random(seed);
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = rand32();
    r[31] = 1'b0;  // keep it positive
    return int'(r) % n;
  endfunction

  // mostly mapped words, sometimes anywhere in the 4 KB window
  function automatic logic [9:0] pick_addr();
    if (rand_below(8) == 0) begin
      return 10'(rand32());
    end
    return 10'(rand_below(14));
  endfunction

  // writable bits per setting register
  function automatic logic [31:0] field_mask(input logic [11:0] off);
    case (off)
      12'h00c, 12'h010, 12'h014: return 32'h0000_1fff;  // 13 bit cube
      12'h018, 12'h020, 12'h024: return 32'hffff_ffe0;  // 32B aligned
      12'h01c:                   return 32'hffff_ffff;
      12'h02c:                   return 32'h0000_0003;
      default:                   return 32'h0000_0001;  // ram type, dma en
    endcase
  endfunction

  function automatic logic [31:0] model_read(input logic [11:0] off);
    logic [31:0] v;
    logic [1:0]  st0;
    logic [1:0]  st1;
    logic [3:0]  idx;
    v = '0;
    idx = off[5:2] - 4'd3;
    // idle 0, running 1, pending 2
    st0 = !en_m[0] ? 2'd0 : (consumer_m ? 2'd2 : 2'd1);
    st1 = !en_m[1] ? 2'd0 : (!consumer_m ? 2'd2 : 2'd1);
    if (off == 12'h000) begin
      v[0]  = producer_m;
      v[16] = consumer_m;
    end else if (off == 12'h004) begin
      v[1:0]   = st0;
      v[17:16] = st1;
    end else if (off == 12'h008) begin
      v[0] = en_m[producer_m];
    end else if (off >= 12'h00c && off <= 12'h030) begin
      v = regs_m[producer_m][idx];
    end else if (off == 12'h034) begin
      v = producer_m ? dp2reg_d1_perf_read_stall : dp2reg_d0_perf_read_stall;
    end
    return v;  // anything else reads zero
  endfunction

  // one clock edge of the model, from inputs seen at that edge
  task automatic model_edge();
    logic [11:0] off;
    logic        wr;
    logic        np;
    logic [31:0] dat;
    logic [31:0] rdat;
    logic [3:0]  idx;
    logic        g;
    logic        ori;
    logic        p_nxt;
    logic        c_nxt;
    logic [1:0]  en_nxt;
    off    = {m_pd[9:0], 2'b00};
    wr     = m_pd[54];
    np     = m_pd[55];
    dat    = m_pd[53:22];
    idx    = off[5:2] - 4'd3;
    rdat   = model_read(off);  // before any commit
    g      = producer_m;
    p_nxt  = producer_m;
    c_nxt  = consumer_m;
    en_nxt = en_m;
    resp_vld_m = m_vld && (!wr || np);
    if (resp_vld_m) begin
      resp_pd_m = {wr, 1'b0, wr ? 32'h0 : rdat};
    end
    if (dp2reg_done) begin
      c_nxt = ~consumer_m;
      en_nxt[consumer_m] = 1'b0;
    end
    if (m_vld && wr) begin
      if (off == 12'h000) begin
        p_nxt = dat[0];
      end else if (off == 12'h008 && !en_m[g]) begin
        en_nxt[g] = dat[0];  // beats a same-edge done
      end else if (off >= 12'h00c && off <= 12'h030 && !en_m[g]) begin
        regs_m[g][idx] = dat & field_mask(off);
      end
    end
    ori       = en_m[consumer_m];
    op_hist   = dp2reg_done ? 3'b000 : {op_hist[1:0], ori};
    slcg_hist = {slcg_hist[1:0], ori};
    producer_m = p_nxt;
    consumer_m = c_nxt;
    en_m       = en_nxt;
    m_vld = csb2cdp_rdma_req_pvld;
    if (csb2cdp_rdma_req_pvld) begin
      m_pd = csb2cdp_rdma_req_pd;
    end
  endtask

  task automatic compare_outputs();
    logic c;
    c = consumer_m;  // outputs show the consumed group
    check_val("csb2cdp_rdma_req_prdy", 64'(csb2cdp_rdma_req_prdy), 64'(1'b1));
    check_val("cdp_rdma2csb_resp_valid", 64'(cdp_rdma2csb_resp_valid), 64'(resp_vld_m));
    if (resp_vld_m) begin
      check_val("cdp_rdma2csb_resp_pd", 64'(cdp_rdma2csb_resp_pd), 64'(resp_pd_m));
    end
    check_val("reg2dp_op_en", 64'(reg2dp_op_en), 64'(op_hist[2]));
    check_val("slcg_op_en", 64'(slcg_op_en), 64'(slcg_hist[2]));
    check_val("reg2dp_width", 64'(reg2dp_width), 64'(regs_m[c][0][12:0]));
    check_val("reg2dp_height", 64'(reg2dp_height), 64'(regs_m[c][1][12:0]));
    check_val("reg2dp_channel", 64'(reg2dp_channel), 64'(regs_m[c][2][12:0]));
    check_val("reg2dp_src_base_addr_low", 64'(reg2dp_src_base_addr_low),
              64'(regs_m[c][3][31:5]));
    check_val("reg2dp_src_base_addr_high", 64'(reg2dp_src_base_addr_high),
              64'(regs_m[c][4]));
    check_val("reg2dp_src_line_stride", 64'(reg2dp_src_line_stride),
              64'(regs_m[c][5][31:5]));
    check_val("reg2dp_src_surface_stride", 64'(reg2dp_src_surface_stride),
              64'(regs_m[c][6][31:5]));
    check_val("reg2dp_src_ram_type", 64'(reg2dp_src_ram_type), 64'(regs_m[c][7][0]));
    check_val("reg2dp_input_data", 64'(reg2dp_input_data), 64'(regs_m[c][8][1:0]));
    check_val("reg2dp_dma_en", 64'(reg2dp_dma_en), 64'(regs_m[c][9][0]));
  endtask

  // edge, model update, then check while outputs are settled
  task automatic tick();
    @(posedge nvdla_core_clk);
    model_edge();
    #1;
    compare_outputs();
  endtask

  task automatic send_req(input logic wr, input logic np, input logic [9:0] waddr,
                          input logic [31:0] data);
    logic [6:0] junk;
    junk = 7'(rand32());  // unused request fields
    csb2cdp_rdma_req_pvld = 1'b1;
    csb2cdp_rdma_req_pd   = {junk, np, wr, data, 12'h000, waddr};
    tick();
    csb2cdp_rdma_req_pvld = 1'b0;
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////
  initial begin
    int          op;
    logic [31:0] data;
    seed        = 63030;
    cycle_count = 0;
    nvdla_core_clk            = 1'b0;
    nvdla_core_rstn           = 1'b0;
    csb2cdp_rdma_req_pd       = '0;
    csb2cdp_rdma_req_pvld     = 1'b0;
    dp2reg_done               = 1'b0;
    dp2reg_d0_perf_read_stall = '0;
    dp2reg_d1_perf_read_stall = '0;
    m_vld      = 1'b0;
    m_pd       = '0;
    producer_m = 1'b0;
    consumer_m = 1'b0;
    en_m       = '0;
    regs_m     = '{default: 32'h0};
    op_hist    = '0;
    slcg_hist  = '0;
    resp_vld_m = 1'b0;
    resp_pd_m  = '0;

    repeat (reset_cycles) @(posedge nvdla_core_clk);
    #1;
    nvdla_core_rstn = 1'b1;
    compare_outputs();  // all quiet out of reset

    for (int i = 0; i < num_ops; i++) begin
      op = rand_below(10);
      case (op)
        0, 1, 2: begin
          send_req(1'b0, rand_below(2) == 1, pick_addr(), rand32());
        end
        3, 4, 5: begin
          send_req(1'b1, rand_below(2) == 1, pick_addr(), rand32());
        end
        6: begin
          data = rand32();
          data[0] = rand_below(4) != 0;  // mostly kick
          send_req(1'b1, rand_below(2) == 1, 10'h002, data);
        end
        7: begin
          dp2reg_done = 1'b1;
          tick();
          dp2reg_done = 1'b0;
        end
        8: begin
          dp2reg_d0_perf_read_stall = rand32();
          dp2reg_d1_perf_read_stall = rand32();
          tick();
        end
        default: begin
          send_req(1'b1, rand_below(2) == 1, 10'h000, rand32());  // flip producer
        end
      endcase
      repeat (rand_below(3)) tick();  // idle gap
    end
    repeat (4) tick();  // drain last responses

    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* hdl/cdp_rdma_reg.sv */
// cdp rdma register file top
`timescale 1ns/1ps

module cdp_rdma_reg (
  input  logic                                 nvdla_core_clk,
  input  logic                                 nvdla_core_rstn,
  input  logic [csb_pkg::csb_req_w-1:0]         csb2cdp_rdma_req_pd,
  input  logic                                 csb2cdp_rdma_req_pvld,
  output logic                                 csb2cdp_rdma_req_prdy,
  output logic [csb_pkg::csb_resp_w-1:0]        cdp_rdma2csb_resp_pd,
  output logic                                 cdp_rdma2csb_resp_valid,
  input  logic                                 dp2reg_done,
  input  logic [csb_pkg::csb_data_w-1:0]        dp2reg_d0_perf_read_stall,
  input  logic [csb_pkg::csb_data_w-1:0]        dp2reg_d1_perf_read_stall,
  output logic [cdp_rdma_reg_pkg::cube_w-1:0]   reg2dp_width,
  output logic [cdp_rdma_reg_pkg::cube_w-1:0]   reg2dp_height,
  output logic [cdp_rdma_reg_pkg::cube_w-1:0]   reg2dp_channel,
  output logic [cdp_rdma_reg_pkg::stride_w-1:0] reg2dp_src_base_addr_low,
  output logic [csb_pkg::csb_data_w-1:0]        reg2dp_src_base_addr_high,
  output logic [cdp_rdma_reg_pkg::stride_w-1:0] reg2dp_src_line_stride,
  output logic [cdp_rdma_reg_pkg::stride_w-1:0] reg2dp_src_surface_stride,
  output logic                                 reg2dp_src_ram_type,
  output logic [1:0]                           reg2dp_input_data,
  output logic                                 reg2dp_dma_en,
  output logic                                 reg2dp_op_en,
  output logic                                 slcg_op_en
);
  import cdp_rdma_reg_pkg::*;

  rdma_cfg_t  d0_cfg;
  rdma_cfg_t  d1_cfg;
  rdma_cfg_t  cfg;       // active group
  logic       producer;
  logic       consumer;
  logic [1:0] status_0;
  logic [1:0] status_1;
  logic       d0_trigger;
  logic       d1_trigger;
  logic       d0_op_en;
  logic       d1_op_en;

  reg_bus_if host_bus ();
  reg_bus_if s_bus ();
  reg_bus_if d0_bus ();
  reg_bus_if d1_bus ();

  ////////////////////////////////////////
  // csb side
  ////////////////////////////////////////
  csb_reg_bridge u_bridge (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .req_pvld        (csb2cdp_rdma_req_pvld),
    .req_pd          (csb2cdp_rdma_req_pd),
    .req_prdy        (csb2cdp_rdma_req_prdy),
    .resp_valid      (cdp_rdma2csb_resp_valid),
    .resp_pd         (cdp_rdma2csb_resp_pd),
    .bus             (host_bus.host)
  );

  cdp_rdma_pingpong_ctrl u_ctrl (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .host            (host_bus.file),
    .s_bus           (s_bus.host),
    .d0_bus          (d0_bus.host),
    .d1_bus          (d1_bus.host),
    .producer        (producer),
    .d0_cfg          (d0_cfg),
    .d1_cfg          (d1_cfg),
    .d0_trigger      (d0_trigger),
    .d1_trigger      (d1_trigger),
    .d0_op_en        (d0_op_en),
    .d1_op_en        (d1_op_en),
    .consumer        (consumer),
    .status_0        (status_0),
    .status_1        (status_1),
    .done            (dp2reg_done),
    .cfg             (cfg),
    .op_en           (reg2dp_op_en),
    .slcg_op_en      (slcg_op_en)
  );

  ////////////////////////////////////////
  // register groups
  ////////////////////////////////////////
  cdp_rdma_reg_single u_single (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .bus             (s_bus.file),
    .producer        (producer),
    .consumer        (consumer),
    .status_0        (status_0),
    .status_1        (status_1)
  );

  cdp_rdma_reg_dual u_dual_d0 (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .bus             (d0_bus.file),
    .cfg             (d0_cfg),
    .op_en_trigger   (d0_trigger),
    .op_en           (d0_op_en),
    .perf_read_stall (dp2reg_d0_perf_read_stall)
  );

  cdp_rdma_reg_dual u_dual_d1 (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .bus             (d1_bus.file),
    .cfg             (d1_cfg),
    .op_en_trigger   (d1_trigger),
    .op_en           (d1_op_en),
    .perf_read_stall (dp2reg_d1_perf_read_stall)
  );

  // flatten active settings
  assign reg2dp_width              = cfg.width;
  assign reg2dp_height             = cfg.height;
  assign reg2dp_channel            = cfg.channel;
  assign reg2dp_src_base_addr_low  = cfg.base_low;
  assign reg2dp_src_base_addr_high = cfg.base_high;
  assign reg2dp_src_line_stride    = cfg.line_stride;
  assign reg2dp_src_surface_stride = cfg.surf_stride;
  assign reg2dp_src_ram_type       = cfg.ram_type;
  assign reg2dp_input_data         = cfg.input_data;
  assign reg2dp_dma_en             = cfg.dma_en;

endmodule

/* hdl/cdp_rdma_pingpong_ctrl.sv */
// ping-pong group control
`timescale 1ns/1ps

module cdp_rdma_pingpong_ctrl (
  input  logic                        nvdla_core_clk,
  input  logic                        nvdla_core_rstn,
  reg_bus_if.file                     host,
  reg_bus_if.host                     s_bus,
  reg_bus_if.host                     d0_bus,
  reg_bus_if.host                     d1_bus,
  input  logic                        producer,
  input  cdp_rdma_reg_pkg::rdma_cfg_t d0_cfg,
  input  cdp_rdma_reg_pkg::rdma_cfg_t d1_cfg,
  input  logic                        d0_trigger,
  input  logic                        d1_trigger,
  output logic                        d0_op_en,
  output logic                        d1_op_en,
  output logic                        consumer,
  output logic [1:0]                  status_0,
  output logic [1:0]                  status_1,
  input  logic                        done,
  output cdp_rdma_reg_pkg::rdma_cfg_t cfg,
  output logic                        op_en,
  output logic                        slcg_op_en
);
  import csb_pkg::*;
  import cdp_rdma_reg_pkg::*;

  logic                   select_s;
  logic                   select_d0;
  logic                   select_d1;
  logic                   op_en_ori;    // enable of consumed group
  logic [op_en_depth-1:0] op_en_pipe;
  logic [slcg_depth-1:0]  slcg_pipe;

  ////////////////////////////////////////
  // address decode
  ////////////////////////////////////////
  assign select_s  = host.offset < dual_base;
  assign select_d0 = ~select_s & ~producer;  // software fills the producer side
  assign select_d1 = ~select_s & producer;

  assign s_bus.offset  = host.offset;
  assign d0_bus.offset = host.offset;
  assign d1_bus.offset = host.offset;

  assign s_bus.wr_data  = host.wr_data;
  assign d0_bus.wr_data = host.wr_data;
  assign d1_bus.wr_data = host.wr_data;

  // a running or pending group is locked
  assign s_bus.wr_en  = host.wr_en & select_s;
  assign d0_bus.wr_en = host.wr_en & select_d0 & ~d0_op_en;
  assign d1_bus.wr_en = host.wr_en & select_d1 & ~d1_op_en;

  assign host.rd_data = ({csb_data_w{select_s}}  & s_bus.rd_data)  |
                        ({csb_data_w{select_d0}} & d0_bus.rd_data) |
                        ({csb_data_w{select_d1}} & d1_bus.rd_data);

  ////////////////////////////////////////
  // consumer pointer and enables
  ////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      consumer <= 1'b0;
    end else if (done) begin
      consumer <= ~consumer;  // hop to other group
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      d0_op_en <= 1'b0;
      d1_op_en <= 1'b0;
    end else begin
      // set only from idle, trigger wins over done
      if (!d0_op_en && d0_trigger) begin
        d0_op_en <= host.wr_data[0];
      end else if (done && !consumer) begin
        d0_op_en <= 1'b0;
      end
      if (!d1_op_en && d1_trigger) begin
        d1_op_en <= host.wr_data[0];
      end else if (done && consumer) begin
        d1_op_en <= 1'b0;
      end
    end
  end

  // status words
  always_comb begin
    status_0 = !d0_op_en ? st_idle : (consumer ? st_pending : st_running);
    status_1 = !d1_op_en ? st_idle : (!consumer ? st_pending : st_running);
  end

  ////////////////////////////////////////
  // op_en pipe and clock gate delay
  ////////////////////////////////////////
  assign op_en_ori = consumer ? d1_op_en : d0_op_en;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      op_en_pipe <= '0;
      slcg_pipe  <= '0;
    end else begin
      op_en_pipe <= done ? '0 : {op_en_pipe[op_en_depth-2:0], op_en_ori};  // flush on done
      slcg_pipe  <= {slcg_pipe[slcg_depth-2:0], op_en_ori};  // clock keeps running
    end
  end

  assign op_en      = op_en_pipe[op_en_depth-1];
  assign slcg_op_en = slcg_pipe[slcg_depth-1];

  // datapath sees the consumed group
  assign cfg = consumer ? d1_cfg : d0_cfg;

endmodule

/* hdl/cdp_rdma_reg_dual.sv */
// ping-pong register group
`timescale 1ns/1ps

module cdp_rdma_reg_dual (
  input  logic                           nvdla_core_clk,
  input  logic                           nvdla_core_rstn,
  reg_bus_if.file                        bus,
  output cdp_rdma_reg_pkg::rdma_cfg_t    cfg,
  output logic                           op_en_trigger,
  input  logic                           op_en,
  input  logic [csb_pkg::csb_data_w-1:0] perf_read_stall
);
  import cdp_rdma_reg_pkg::*;

  // enable itself lives in the ctrl block
  assign op_en_trigger = bus.wr_en && (bus.offset == ofs_op_enable);

  ////////////////////////////////////////
  // settings write
  ////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cfg <= '0;
    end else if (bus.wr_en) begin  // already gated by op_en upstream
      case (bus.offset)
        ofs_width:       cfg.width       <= bus.wr_data[cube_w-1:0];
        ofs_height:      cfg.height      <= bus.wr_data[cube_w-1:0];
        ofs_channel:     cfg.channel     <= bus.wr_data[cube_w-1:0];
        ofs_base_low:    cfg.base_low    <= bus.wr_data[31:5];  // 32B aligned
        ofs_base_high:   cfg.base_high   <= bus.wr_data;
        ofs_line_stride: cfg.line_stride <= bus.wr_data[31:5];
        ofs_surf_stride: cfg.surf_stride <= bus.wr_data[31:5];
        ofs_ram_type:    cfg.ram_type    <= bus.wr_data[0];
        ofs_input_data:  cfg.input_data  <= bus.wr_data[1:0];
        ofs_dma_en:      cfg.dma_en      <= bus.wr_data[0];
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////
  // readback
  ////////////////////////////////////////
  always_comb begin
    bus.rd_data = '0;
    case (bus.offset)
      ofs_op_enable: begin
        bus.rd_data[0] = op_en;
      end
      ofs_width: begin
        bus.rd_data[cube_w-1:0] = cfg.width;
      end
      ofs_height: begin
        bus.rd_data[cube_w-1:0] = cfg.height;
      end
      ofs_channel: begin
        bus.rd_data[cube_w-1:0] = cfg.channel;
      end
      ofs_base_low: begin
        bus.rd_data[31:5] = cfg.base_low;  // low bits read zero
      end
      ofs_base_high: begin
        bus.rd_data = cfg.base_high;
      end
      ofs_line_stride: begin
        bus.rd_data[31:5] = cfg.line_stride;
      end
      ofs_surf_stride: begin
        bus.rd_data[31:5] = cfg.surf_stride;
      end
      ofs_ram_type: begin
        bus.rd_data[0] = cfg.ram_type;
      end
      ofs_input_data: begin
        bus.rd_data[1:0] = cfg.input_data;
      end
      ofs_dma_en: begin
        bus.rd_data[0] = cfg.dma_en;
      end
      ofs_perf_stall: begin
        bus.rd_data = perf_read_stall;  // live counter from datapath
      end
      default: ;
    endcase
  end

endmodule

/* hdl/cdp_rdma_reg_single.sv */
// single register group
`timescale 1ns/1ps

module cdp_rdma_reg_single (
  input  logic       nvdla_core_clk,
  input  logic       nvdla_core_rstn,
  reg_bus_if.file    bus,
  output logic       producer,
  input  logic       consumer,
  input  logic [1:0] status_0,
  input  logic [1:0] status_1
);
  import cdp_rdma_reg_pkg::*;

  // producer pointer, only writable bit here
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      producer <= 1'b0;
    end else if (bus.wr_en && bus.offset == ofs_pointer) begin
      producer <= bus.wr_data[0];
    end
  end

  ////////////////////////////////////////
  // readback
  ////////////////////////////////////////
  always_comb begin
    bus.rd_data = '0;  // unmapped reads zero
    case (bus.offset)
      ofs_pointer: begin
        bus.rd_data[0]  = producer;
        bus.rd_data[16] = consumer;  // read only
      end
      ofs_status: begin
        bus.rd_data[1:0]   = status_0;
        bus.rd_data[17:16] = status_1;
      end
      default: ;
    endcase
  end

endmodule

/* hdl/csb_reg_bridge.sv */
// csb to register bridge
`timescale 1ns/1ps

module csb_reg_bridge (
  input  logic                          nvdla_core_clk,
  input  logic                          nvdla_core_rstn,
  input  logic                          req_pvld,
  input  logic [csb_pkg::csb_req_w-1:0]  req_pd,
  output logic                          req_prdy,
  output logic                          resp_valid,
  output logic [csb_pkg::csb_resp_w-1:0] resp_pd,
  reg_bus_if.host                       bus
);
  import csb_pkg::*;
  import cdp_rdma_reg_pkg::*;

  logic                  req_pvld_r;
  logic [csb_req_w-1:0]  req_pd_r;
  logic [csb_addr_w-1:0] req_addr;
  logic                  req_write;
  logic                  req_nposted;
  logic                  rd_en;
  logic                  npwr_en;
  logic [csb_resp_w-1:0] resp_nxt;

  assign req_prdy = 1'b1;  // never stalls

  ////////////////////////////////////////
  // request capture
  ////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      req_pvld_r <= 1'b0;
    end else begin
      req_pvld_r <= req_pvld;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (req_pvld) begin
      req_pd_r <= req_pd;  // payload only on valid
    end
  end

  // unpack
  assign req_addr    = req_pd_r[csb_addr_lsb +: csb_addr_w];
  assign req_write   = req_pd_r[csb_write_bit];
  assign req_nposted = req_pd_r[csb_nposted_bit];

  // word address to byte offset
  assign bus.offset  = {req_addr[reg_off_w-3:0], 2'b00};
  assign bus.wr_data = req_pd_r[csb_wdat_lsb +: csb_data_w];
  assign bus.wr_en   = req_pvld_r & req_write;

  assign rd_en   = req_pvld_r & ~req_write;
  assign npwr_en = req_pvld_r & req_write & req_nposted;

  ////////////////////////////////////////
  // response
  ////////////////////////////////////////
  always_comb begin
    resp_nxt = '0;
    if (rd_en) begin
      resp_nxt[csb_data_w-1:0] = bus.rd_data;  // write resp carries zero data
    end
    resp_nxt[csb_err_bit]  = 1'b0;       // no error reporting
    resp_nxt[csb_kind_bit] = req_write;  // kind follows direction
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= rd_en | npwr_en;  // posted writes stay silent
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (rd_en || npwr_en) begin
      resp_pd <= resp_nxt;  // holds otherwise
    end
  end

endmodule

/* hdl/reg_bus_if.sv */
// register access bus
`timescale 1ns/1ps

interface reg_bus_if;
  import csb_pkg::*;
  import cdp_rdma_reg_pkg::*;

  logic [reg_off_w-1:0]  offset;   // byte offset
  logic [csb_data_w-1:0] wr_data;
  logic                  wr_en;    // commits at the edge
  logic [csb_data_w-1:0] rd_data;  // combinational read

  // requester side
  modport host (
    output offset, wr_data, wr_en,
    input  rd_data
  );

  // register side
  modport file (
    input  offset, wr_data, wr_en,
    output rd_data
  );

endinterface

/* hdl/cdp_rdma_reg_pkg.sv */
// cdp rdma register map
package cdp_rdma_reg_pkg;

  localparam int reg_off_w = 12;  // byte offset in 4 KB window

  ////////////////////////////////////////
  // register offsets
  ////////////////////////////////////////
  // single group
  localparam logic [reg_off_w-1:0] ofs_pointer     = 12'h000;  // producer 0, consumer 16
  localparam logic [reg_off_w-1:0] ofs_status      = 12'h004;
  // ping-pong groups
  localparam logic [reg_off_w-1:0] ofs_op_enable   = 12'h008;
  localparam logic [reg_off_w-1:0] ofs_width       = 12'h00c;
  localparam logic [reg_off_w-1:0] ofs_height      = 12'h010;
  localparam logic [reg_off_w-1:0] ofs_channel     = 12'h014;
  localparam logic [reg_off_w-1:0] ofs_base_low    = 12'h018;  // bits 31:5
  localparam logic [reg_off_w-1:0] ofs_base_high   = 12'h01c;
  localparam logic [reg_off_w-1:0] ofs_line_stride = 12'h020;  // bits 31:5
  localparam logic [reg_off_w-1:0] ofs_surf_stride = 12'h024;  // bits 31:5
  localparam logic [reg_off_w-1:0] ofs_ram_type    = 12'h028;
  localparam logic [reg_off_w-1:0] ofs_input_data  = 12'h02c;
  localparam logic [reg_off_w-1:0] ofs_dma_en      = 12'h030;
  localparam logic [reg_off_w-1:0] ofs_perf_stall  = 12'h034;  // read only

  localparam logic [reg_off_w-1:0] dual_base = ofs_op_enable;  // below is single group

  // field widths
  localparam int cube_w   = 13;
  localparam int stride_w = 27;

  // group status codes
  localparam logic [1:0] st_idle    = 2'd0;
  localparam logic [1:0] st_running = 2'd1;
  localparam logic [1:0] st_pending = 2'd2;

  // output pipelines
  localparam int op_en_depth = 3;
  localparam int slcg_depth  = 3;

  // settings of one ping-pong group
  typedef struct packed {
    logic [cube_w-1:0]             width;
    logic [cube_w-1:0]             height;
    logic [cube_w-1:0]             channel;
    logic [stride_w-1:0]           base_low;
    logic [csb_pkg::csb_data_w-1:0] base_high;
    logic [stride_w-1:0]           line_stride;
    logic [stride_w-1:0]           surf_stride;
    logic                          ram_type;
    logic [1:0]                    input_data;
    logic                          dma_en;
  } rdma_cfg_t;

endpackage

/* hdl/csb_pkg.sv */
// csb packet layout
package csb_pkg;

  ////////////////////////////////////////
  // packet and field widths
  ////////////////////////////////////////
  localparam int csb_req_w  = 63;  // request packet
  localparam int csb_resp_w = 34;  // response packet
  localparam int csb_addr_w = 22;  // word address
  localparam int csb_data_w = 32;

  ////////////////////////////////////////
  // request field positions
  ////////////////////////////////////////
  localparam int csb_addr_lsb    = 0;   // addr at 21:0
  localparam int csb_wdat_lsb    = 22;  // write data at 53:22
  localparam int csb_write_bit   = 54;
  localparam int csb_nposted_bit = 55;

  // response field positions, read data sits at 31:0
  localparam int csb_err_bit  = 32;
  localparam int csb_kind_bit = 33;  // 0 read, 1 write

endpackage
